/* Bender.yml */
package:
  name: radio_core

sources:
  - common/radio_pkg.sv
  - logic/radio_demux.sv
  - logic/word_fifo.sv
  - ctrl/ctrl_proc.sv
  - ctrl/settings_regs.sv
  - logic/tx_ack_gen.sv
  - logic/radio_out_mux.sv
  - logic/radio_core.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/radio_core_properties.sv
      - sim/radio_core_tb.sv

/* common/radio_pkg.sv */
// Radio packet core definitions
package radio_pkg;

   //////////////////////////////
   // Widths
   typedef logic [63:0] word_t;
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [11:0] seqnum_t;
   typedef logic [31:0] sid_t;
   typedef logic [1:0]  dest_t;
   typedef logic [3:0]  pkt_type_t;
   typedef logic [1:0]  rb_sel_t;

   typedef struct packed {
      word_t data;
      logic  last;
   } stream_word_t;

   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   // Route select from the low bits of the stream ID
   typedef enum dest_t {
      DEST_TX    = 2'd0,
      DEST_CTRL  = 2'd1,
      DEST_RXFC  = 2'd2,
      DEST_RXCMD = 2'd3
   } dest_e;

   typedef enum logic [2:0] {
      CS_HDR,
      CS_PAYLOAD,
      CS_DRAIN,
      CS_WRITE,
      CS_RESP_HDR,
      CS_RESP_DATA
   } ctrl_state_e;

   //////////////////////////////
   // Packet codes
   localparam pkt_type_t PKT_TYPE_RESP = 4'hE;
   localparam pkt_type_t PKT_TYPE_FC   = 4'h4;
   localparam logic [15:0] PKT_LEN     = 16'd16;

   //////////////////////////////
   // Setting addresses
   localparam set_addr_t SR_DACSYNC   = 8'd5;
   localparam set_addr_t SR_TEST      = 8'd7;
   localparam set_addr_t SR_MISC_OUTS = 8'd24;
   localparam set_addr_t SR_READBACK  = 8'd32;
   localparam set_addr_t SR_TX_ACK_EN = 8'd68;

   // Readback selects
   localparam rb_sel_t RB_TEST      = 2'd0;
   localparam rb_sel_t RB_MISC      = 2'd1;
   localparam rb_sel_t RB_RADIO_NUM = 2'd2;
   localparam rb_sel_t RB_TX_COUNT  = 2'd3;

   // Reply header goes back to the sender, so the SID halves swap
   function automatic word_t make_hdr(input pkt_type_t pkt_type, input seqnum_t seqnum,
                                      input sid_t sid);
      return {pkt_type, seqnum, PKT_LEN, sid[15:0], sid[31:16]};
   endfunction

endpackage

/* ctrl/ctrl_proc.sv */
// Settings command processor
`timescale 1ns/10ps

module ctrl_proc (
   input  logic                    bus_clk,
   input  logic                    bus_rst,
   input  radio_pkg::stream_word_t i_cmd,
   input  logic                    i_cmd_tvalid,
   output logic                    o_cmd_tready,
   output radio_pkg::set_bus_t     o_set,
   input  radio_pkg::word_t        i_readback,
   output radio_pkg::stream_word_t o_resp,
   output logic                    o_resp_tvalid,
   input  logic                    i_resp_tready
);

   radio_pkg::ctrl_state_e state;
   radio_pkg::seqnum_t     seqnum_q;
   radio_pkg::sid_t        sid_q;
   radio_pkg::word_t       rb_q;
   logic                   cmd_xfer;
   logic                   resp_xfer;

   assign o_cmd_tready = (state == radio_pkg::CS_HDR) || (state == radio_pkg::CS_PAYLOAD) ||
                         (state == radio_pkg::CS_DRAIN);
   assign cmd_xfer     = i_cmd_tvalid & o_cmd_tready;

   // Response is header then captured readback
   assign o_resp_tvalid = (state == radio_pkg::CS_RESP_HDR) || (state == radio_pkg::CS_RESP_DATA);
   assign o_resp.data   = (state == radio_pkg::CS_RESP_HDR) ?
                          radio_pkg::make_hdr(radio_pkg::PKT_TYPE_RESP, seqnum_q, sid_q) : rb_q;
   assign o_resp.last   = (state == radio_pkg::CS_RESP_DATA);
   assign resp_xfer     = o_resp_tvalid & i_resp_tready;

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         state    <= radio_pkg::CS_HDR;
         seqnum_q <= '0;
         sid_q    <= '0;
         rb_q     <= '0;
         o_set    <= '0;
      end else begin
         o_set.stb <= 1'b0;
         case (state)
            radio_pkg::CS_HDR: if (cmd_xfer) begin
               seqnum_q <= i_cmd.data[59:48];
               sid_q    <= i_cmd.data[31:0];
               // A header-only packet carries nothing to write
               state    <= i_cmd.last ? radio_pkg::CS_HDR : radio_pkg::CS_PAYLOAD;
            end
            radio_pkg::CS_PAYLOAD: if (cmd_xfer) begin
               o_set.stb  <= 1'b1;
               o_set.addr <= i_cmd.data[39:32];
               o_set.data <= i_cmd.data[31:0];
               state      <= i_cmd.last ? radio_pkg::CS_WRITE : radio_pkg::CS_DRAIN;
            end
            radio_pkg::CS_DRAIN: if (cmd_xfer && i_cmd.last)
               state <= radio_pkg::CS_RESP_HDR;
            // Strobe cycle, registers take the write at its end
            radio_pkg::CS_WRITE:
               state <= radio_pkg::CS_RESP_HDR;
            radio_pkg::CS_RESP_HDR: if (resp_xfer) begin
               rb_q  <= i_readback;
               state <= radio_pkg::CS_RESP_DATA;
            end
            radio_pkg::CS_RESP_DATA: if (resp_xfer)
               state <= radio_pkg::CS_HDR;
            default:
               state <= radio_pkg::CS_HDR;
         endcase
      end
   end

endmodule

/* ctrl/settings_regs.sv */
// Setting registers and readback
`timescale 1ns/10ps

module settings_regs #(
   parameter int RADIO_NUM = 0
) (
   input  logic                 bus_clk,
   input  logic                 bus_rst,
   input  radio_pkg::set_bus_t  i_set,
   input  radio_pkg::set_data_t i_misc_ins,
   input  radio_pkg::set_data_t i_tx_count,
   output radio_pkg::set_data_t o_misc_outs,
   output logic                 o_sync_dacs,
   output logic                 o_ack_en,
   output radio_pkg::word_t     o_readback
);

   radio_pkg::set_data_t test_q;
   radio_pkg::rb_sel_t   rb_sel_q;

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         test_q      <= '0;
         rb_sel_q    <= '0;
         o_misc_outs <= '0;
         o_ack_en    <= 1'b0;
         o_sync_dacs <= 1'b0;
      end else begin
         // Any write to the DAC sync address fires one pulse
         o_sync_dacs <= i_set.stb && (i_set.addr == radio_pkg::SR_DACSYNC);
         if (i_set.stb) begin
            case (i_set.addr)
               radio_pkg::SR_TEST:      test_q      <= i_set.data;
               radio_pkg::SR_MISC_OUTS: o_misc_outs <= i_set.data;
               radio_pkg::SR_READBACK:  rb_sel_q    <= i_set.data[1:0];
               radio_pkg::SR_TX_ACK_EN: o_ack_en    <= i_set.data[0];
               default: ;
            endcase
         end
      end
   end

   //////////////////////////////
   // Readback mux
   always_comb begin
      case (rb_sel_q)
         radio_pkg::RB_TEST:      o_readback = {32'd0, test_q};
         radio_pkg::RB_MISC:      o_readback = {i_misc_ins, o_misc_outs};
         radio_pkg::RB_RADIO_NUM: o_readback = radio_pkg::word_t'(RADIO_NUM);
         radio_pkg::RB_TX_COUNT:  o_readback = {32'd0, i_tx_count};
         default:                 o_readback = '0;
      endcase
   end

endmodule

/* logic/radio_core.sv */
// Radio bus-side packet core
`timescale 1ns/10ps

module radio_core #(
   parameter int RADIO_NUM       = 0,
   parameter int FIFO_DEPTH_LOG2 = 5
) (
   input  logic                    bus_clk,
   input  logic                    bus_rst,
   input  radio_pkg::stream_word_t i_in,
   input  logic                    i_in_tvalid,
   output logic                    o_in_tready,
   output radio_pkg::stream_word_t o_out,
   output logic                    o_out_tvalid,
   input  logic                    i_out_tready,
   output radio_pkg::stream_word_t o_tx,
   output logic                    o_tx_tvalid,
   input  logic                    i_tx_tready,
   input  radio_pkg::set_data_t    i_misc_ins,
   output radio_pkg::set_data_t    o_misc_outs,
   output logic                    o_sync_dacs
);

   radio_pkg::stream_word_t tx_pre, tx_post, ctrl, resp, ack;
   logic                    tx_pre_tvalid, tx_pre_tready, tx_post_tvalid, tx_post_tready;
   logic                    ctrl_tvalid, ctrl_tready, resp_tvalid, resp_tready;
   logic                    ack_tvalid, ack_tready, ack_en;
   radio_pkg::set_bus_t     set_bus;
   radio_pkg::word_t        readback;
   radio_pkg::set_data_t    tx_count;

   //////////////////////////////
   // Inbound side
   radio_demux u_demux (
      .bus_clk, .bus_rst, .i_in, .i_in_tvalid, .o_in_tready,
      .o_tx(tx_pre), .o_tx_tvalid(tx_pre_tvalid), .i_tx_tready(tx_pre_tready),
      .o_ctrl(ctrl), .o_ctrl_tvalid(ctrl_tvalid), .i_ctrl_tready(ctrl_tready));

   word_fifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_tx_fifo (
      .bus_clk, .bus_rst,
      .i_in(tx_pre), .i_in_tvalid(tx_pre_tvalid), .o_in_tready(tx_pre_tready),
      .o_out(tx_post), .o_out_tvalid(tx_post_tvalid), .i_out_tready(tx_post_tready));

   tx_ack_gen u_tx_ack (
      .bus_clk, .bus_rst,
      .i_in(tx_post), .i_in_tvalid(tx_post_tvalid), .o_in_tready(tx_post_tready),
      .o_tx, .o_tx_tvalid, .i_tx_tready, .i_ack_en(ack_en), .o_tx_count(tx_count),
      .o_ack(ack), .o_ack_tvalid(ack_tvalid), .i_ack_tready(ack_tready));

   //////////////////////////////
   // Settings path
   ctrl_proc u_ctrl (
      .bus_clk, .bus_rst,
      .i_cmd(ctrl), .i_cmd_tvalid(ctrl_tvalid), .o_cmd_tready(ctrl_tready),
      .o_set(set_bus), .i_readback(readback),
      .o_resp(resp), .o_resp_tvalid(resp_tvalid), .i_resp_tready(resp_tready));

   settings_regs #(.RADIO_NUM(RADIO_NUM)) u_regs (
      .bus_clk, .bus_rst, .i_set(set_bus), .i_misc_ins, .i_tx_count(tx_count),
      .o_misc_outs, .o_sync_dacs, .o_ack_en(ack_en), .o_readback(readback));

   radio_out_mux u_out_mux (
      .bus_clk, .bus_rst,
      .i_resp(resp), .i_resp_tvalid(resp_tvalid), .o_resp_tready(resp_tready),
      .i_ack(ack), .i_ack_tvalid(ack_tvalid), .o_ack_tready(ack_tready),
      .o_out, .o_out_tvalid, .i_out_tready);

endmodule

/* logic/radio_demux.sv */
// Inbound stream router
`timescale 1ns/10ps

module radio_demux (
   input  logic                   bus_clk,
   input  logic                   bus_rst,
   input  radio_pkg::stream_word_t i_in,
   input  logic                   i_in_tvalid,
   output logic                   o_in_tready,
   output radio_pkg::stream_word_t o_tx,
   output logic                   o_tx_tvalid,
   input  logic                   i_tx_tready,
   output radio_pkg::stream_word_t o_ctrl,
   output logic                   o_ctrl_tvalid,
   input  logic                   i_ctrl_tready
);

   logic              active;
   logic              first;
   radio_pkg::dest_e  dest_q;
   radio_pkg::dest_e  cur_dest;

   // Header word routes itself, later words follow the latched route
   assign cur_dest = first ? radio_pkg::dest_e'(i_in.data[1:0]) : dest_q;

   assign o_tx          = i_in;
   assign o_ctrl        = i_in;
   assign o_tx_tvalid   = active & i_in_tvalid & (cur_dest == radio_pkg::DEST_TX);
   assign o_ctrl_tvalid = active & i_in_tvalid & (cur_dest == radio_pkg::DEST_CTRL);

   always_comb begin
      case (cur_dest)
         radio_pkg::DEST_TX:   o_in_tready = active & i_tx_tready;
         radio_pkg::DEST_CTRL: o_in_tready = active & i_ctrl_tready;
         // RX flow control and RX commands are swallowed
         default:              o_in_tready = active;
      endcase
   end

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         active <= 1'b0;
         first  <= 1'b1;
         dest_q <= radio_pkg::DEST_TX;
      end else begin
         active <= 1'b1;
         if (i_in_tvalid && o_in_tready) begin
            first <= i_in.last;
            if (first)
               dest_q <= cur_dest;
         end
      end
   end

endmodule

/* logic/radio_out_mux.sv */
// Outbound round-robin merge
`timescale 1ns/10ps

module radio_out_mux (
   input  logic                    bus_clk,
   input  logic                    bus_rst,
   input  radio_pkg::stream_word_t i_resp,
   input  logic                    i_resp_tvalid,
   output logic                    o_resp_tready,
   input  radio_pkg::stream_word_t i_ack,
   input  logic                    i_ack_tvalid,
   output logic                    o_ack_tready,
   output radio_pkg::stream_word_t o_out,
   output logic                    o_out_tvalid,
   input  logic                    i_out_tready
);

   logic                    in_pkt;
   logic                    last_sel;
   logic                    pick;
   logic                    cur_sel;
   logic                    can_load;
   logic                    src_valid;
   radio_pkg::stream_word_t src_word;

   // Between packets the source that did not go last wins a tie
   assign pick      = (i_resp_tvalid & i_ack_tvalid) ? ~last_sel : i_ack_tvalid;
   assign cur_sel   = in_pkt ? last_sel : pick;
   assign src_valid = cur_sel ? i_ack_tvalid : i_resp_tvalid;
   assign src_word  = cur_sel ? i_ack : i_resp;

   // Output register refills only once its word has gone
   assign can_load      = ~o_out_tvalid | i_out_tready;
   assign o_resp_tready = can_load & ~cur_sel;
   assign o_ack_tready  = can_load & cur_sel;

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         in_pkt       <= 1'b0;
         last_sel     <= 1'b0;
         o_out        <= '0;
         o_out_tvalid <= 1'b0;
      end else if (can_load) begin
         o_out_tvalid <= src_valid;
         if (src_valid) begin
            o_out    <= src_word;
            in_pkt   <= ~src_word.last;
            last_sel <= cur_sel;
         end
      end
   end

endmodule

/* logic/tx_ack_gen.sv */
// Transmit pass-through and acknowledge
`timescale 1ns/10ps

module tx_ack_gen (
   input  logic                    bus_clk,
   input  logic                    bus_rst,
   input  radio_pkg::stream_word_t i_in,
   input  logic                    i_in_tvalid,
   output logic                    o_in_tready,
   output radio_pkg::stream_word_t o_tx,
   output logic                    o_tx_tvalid,
   input  logic                    i_tx_tready,
   input  logic                    i_ack_en,
   output radio_pkg::set_data_t    o_tx_count,
   output radio_pkg::stream_word_t o_ack,
   output logic                    o_ack_tvalid,
   input  logic                    i_ack_tready
);

   logic               first;
   logic               ack_busy;
   logic               ack_data;
   logic               hold;
   logic               tx_xfer;
   radio_pkg::seqnum_t seqnum_q;
   radio_pkg::sid_t    sid_q;
   radio_pkg::seqnum_t pkt_seqnum;
   radio_pkg::sid_t    pkt_sid;
   radio_pkg::word_t   ack_hdr_q;

   // Packet end waits while the previous acknowledge is still out
   assign hold        = i_in.last & ack_busy;
   assign o_tx        = i_in;
   assign o_tx_tvalid = i_in_tvalid & ~hold;
   assign o_in_tready = i_tx_tready & ~hold;
   assign tx_xfer     = i_in_tvalid & o_in_tready;

   // A single-word packet is its own header
   assign pkt_seqnum = first ? i_in.data[59:48] : seqnum_q;
   assign pkt_sid    = first ? i_in.data[31:0] : sid_q;

   assign o_ack_tvalid = ack_busy;
   assign o_ack.last   = ack_data;
   assign o_ack.data   = ack_data ? {32'd0, o_tx_count} : ack_hdr_q;

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         first      <= 1'b1;
         ack_busy   <= 1'b0;
         ack_data   <= 1'b0;
         seqnum_q   <= '0;
         sid_q      <= '0;
         ack_hdr_q  <= '0;
         o_tx_count <= '0;
      end else begin
         if (tx_xfer) begin
            first <= i_in.last;
            if (first) begin
               seqnum_q <= i_in.data[59:48];
               sid_q    <= i_in.data[31:0];
            end
            if (i_in.last) begin
               o_tx_count <= o_tx_count + 1'b1;
               ack_busy   <= i_ack_en;
               // Acknowledge header stays fixed while the next packet starts
               ack_hdr_q  <= radio_pkg::make_hdr(radio_pkg::PKT_TYPE_FC, pkt_seqnum, pkt_sid);
            end
         end
         if (ack_busy && i_ack_tready) begin
            ack_data <= ~ack_data;
            if (ack_data)
               ack_busy <= 1'b0;
         end
      end
   end

endmodule

/* logic/word_fifo.sv */
// Stream word FIFO
`timescale 1ns/10ps

module word_fifo #(
   parameter int FIFO_DEPTH_LOG2 = 5
) (
   input  logic                    bus_clk,
   input  logic                    bus_rst,
   input  radio_pkg::stream_word_t i_in,
   input  logic                    i_in_tvalid,
   output logic                    o_in_tready,
   output radio_pkg::stream_word_t o_out,
   output logic                    o_out_tvalid,
   input  logic                    i_out_tready
);

   localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

   radio_pkg::stream_word_t        mem [DEPTH];
   logic [FIFO_DEPTH_LOG2-1:0]     wr_ptr;
   logic [FIFO_DEPTH_LOG2-1:0]     rd_ptr;
   logic [FIFO_DEPTH_LOG2:0]       count;
   logic                           wr_en;
   logic                           rd_en;

   assign o_in_tready  = (count != DEPTH[FIFO_DEPTH_LOG2:0]);
   assign o_out_tvalid = (count != '0);
   assign o_out        = mem[rd_ptr];
   assign wr_en        = i_in_tvalid & o_in_tready;
   assign rd_en        = o_out_tvalid & i_out_tready;

   always_ff @(posedge bus_clk) begin
      if (wr_en)
         mem[wr_ptr] <= i_in;
   end

   always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
         if (wr_en && !rd_en)
            count <= count + 1'b1;
         else if (rd_en && !wr_en)
            count <= count - 1'b1;
      end
   end

endmodule

/* sim/radio_core_properties.sv */
// Radio core stream properties
`timescale 1ns/10ps

module radio_core_properties (
   input logic                    bus_clk,
   input logic                    bus_rst,
   input logic                    i_in_tready,
   input radio_pkg::stream_word_t i_out,
   input logic                    i_out_tvalid,
   input logic                    i_out_tready,
   input radio_pkg::stream_word_t i_tx,
   input logic                    i_tx_tvalid,
   input logic                    i_tx_tready,
   input logic                    i_sync_dacs
);

   int unsigned fail_cnt = 0;
   logic        rst_q;

   // Reset seen on the previous edge too, so the DUT registers are already cleared
   always_ff @(posedge bus_clk)
      rst_q <= bus_rst;

   out_hold: assert property (@(posedge bus_clk) disable iff (bus_rst)
      i_out_tvalid && !i_out_tready |=> i_out_tvalid && $stable(i_out))
      else begin
         $error("outbound word dropped or changed while stalled");
         fail_cnt++;
      end

   tx_hold: assert property (@(posedge bus_clk) disable iff (bus_rst)
      i_tx_tvalid && !i_tx_tready |=> i_tx_tvalid && $stable(i_tx))
      else begin
         $error("transmit word dropped or changed while stalled");
         fail_cnt++;
      end

   sync_single: assert property (@(posedge bus_clk) disable iff (bus_rst)
      i_sync_dacs |=> !i_sync_dacs)
      else begin
         $error("DAC sync high for two cycles");
         fail_cnt++;
      end

   rst_quiet: assert property (@(posedge bus_clk)
      bus_rst && rst_q |-> !i_out_tvalid && !i_tx_tvalid && !i_in_tready && !i_sync_dacs)
      else begin
         $error("stream activity during reset");
         fail_cnt++;
      end

endmodule

bind radio_core radio_core_properties u_props (
   .bus_clk, .bus_rst, .i_in_tready(o_in_tready),
   .i_out(o_out), .i_out_tvalid(o_out_tvalid), .i_out_tready,
   .i_tx(o_tx), .i_tx_tvalid(o_tx_tvalid), .i_tx_tready,
   .i_sync_dacs(o_sync_dacs));

/* sim/radio_core_tb.sv */
// Radio core testbench
`timescale 1ns/10ps

module radio_core_tb;

   localparam int RADIO_NUM       = 5;
   localparam int FIFO_DEPTH_LOG2 = 3;
   localparam int N_TEST          = 8;
   localparam int N_MISC          = 4;
   localparam int N_SYNC          = 4;
   localparam int N_MIXED         = 24;
   localparam int N_NOACK         = 8;
   // Packets sent over the whole run
   localparam int NUM_PKTS = 1 + N_TEST + N_MISC + 3 + N_SYNC + 2 + N_MIXED + 2 + N_NOACK;
   localparam int TIMEOUT_CYCLES = 200 * NUM_PKTS + 100;

   logic                    bus_clk;
   logic                    bus_rst;
   radio_pkg::stream_word_t i_in;
   logic                    i_in_tvalid;
   logic                    o_in_tready;
   radio_pkg::stream_word_t o_out;
   logic                    o_out_tvalid;
   logic                    i_out_tready;
   radio_pkg::stream_word_t o_tx;
   logic                    o_tx_tvalid;
   logic                    i_tx_tready;
   radio_pkg::set_data_t    i_misc_ins;
   radio_pkg::set_data_t    o_misc_outs;
   logic                    o_sync_dacs;

   //////////////////////////////
   // Reference model state
   radio_pkg::set_data_t    m_test = '0;
   radio_pkg::set_data_t    m_misc_outs = '0;
   radio_pkg::set_data_t    m_misc_ins = '0;
   radio_pkg::set_data_t    m_tx_count = '0;
   radio_pkg::rb_sel_t      m_rb_sel = '0;
   logic                    m_ack_en = 1'b0;
   int unsigned             m_sync_cnt = 0;
   int unsigned             sync_seen = 0;
   int unsigned             cycle_cnt = 0;
   int                      out_state = 0;
   string                   test_name = "reset";
   radio_pkg::stream_word_t tx_q[$];
   radio_pkg::word_t        resp_hdr_q[$];
   radio_pkg::word_t        resp_data_q[$];
   int unsigned             resp_sync_q[$];
   radio_pkg::word_t        ack_hdr_q[$];
   radio_pkg::word_t        ack_data_q[$];

   tb_clock_gen u_clk (.o_bus_clk(bus_clk), .o_bus_rst(bus_rst));

   radio_core #(.RADIO_NUM(RADIO_NUM), .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) uut (.*);

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("TESTS FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(input string what, input radio_pkg::word_t exp,
                             input radio_pkg::word_t act);
      if (act !== exp)
         fail_run($sformatf("ERR %s %s: expected %h, actual %h", test_name, what, exp, act));
   endtask

   task automatic check_data(input string what, input radio_pkg::set_data_t exp,
                             input radio_pkg::set_data_t act);
      if (act !== exp)
         fail_run($sformatf("ERR %s %s: expected %h, actual %h", test_name, what, exp, act));
   endtask

   task automatic check_count(input string what, input int unsigned exp, input int unsigned act);
      if (act != exp)
         fail_run($sformatf("ERR %s %s: expected %0d, actual %0d", test_name, what, exp, act));
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      if (act !== exp)
         fail_run($sformatf("ERR %s %s: expected %b, actual %b", test_name, what, exp, act));
   endtask

   // Replies go back to the sender, SID halves swapped, length 16
   function automatic radio_pkg::word_t reply_header(input logic [3:0] pkt_type,
                                                     input radio_pkg::seqnum_t seqnum,
                                                     input radio_pkg::sid_t sid);
      return {pkt_type, seqnum, 16'd16, sid[15:0], sid[31:16]};
   endfunction

   function automatic void apply_write(input radio_pkg::set_addr_t addr,
                                       input radio_pkg::set_data_t data);
      case (addr)
         radio_pkg::SR_TEST:      m_test = data;
         radio_pkg::SR_MISC_OUTS: m_misc_outs = data;
         radio_pkg::SR_READBACK:  m_rb_sel = data[1:0];
         radio_pkg::SR_TX_ACK_EN: m_ack_en = data[0];
         radio_pkg::SR_DACSYNC:   m_sync_cnt++;
         default: ;
      endcase
   endfunction

   function automatic radio_pkg::word_t model_readback();
      case (m_rb_sel)
         radio_pkg::RB_TEST:      return {32'd0, m_test};
         radio_pkg::RB_MISC:      return {m_misc_ins, m_misc_outs};
         radio_pkg::RB_RADIO_NUM: return 64'(RADIO_NUM);
         default:                 return {32'd0, m_tx_count};
      endcase
   endfunction

   function automatic radio_pkg::word_t random_header(input radio_pkg::dest_t dest);
      radio_pkg::word_t hdr;
      hdr      = {$urandom, $urandom};
      hdr[1:0] = dest;
      return hdr;
   endfunction

   //////////////////////////////
   // Stimulus
   task automatic send_word(input radio_pkg::word_t data, input logic last);
      i_in.data   = data;
      i_in.last   = last;
      i_in_tvalid = 1'b1;
      @(posedge bus_clk);
      while (!o_in_tready)
         @(posedge bus_clk);
      #2;
      i_in_tvalid = 1'b0;
   endtask

   task automatic send_cmd(input radio_pkg::set_addr_t addr, input radio_pkg::set_data_t data);
      radio_pkg::word_t hdr;
      logic [23:0]      pad;
      int               extra;
      hdr   = random_header(radio_pkg::DEST_CTRL);
      pad   = $urandom;
      extra = $urandom % 2;
      apply_write(addr, data);
      resp_hdr_q.push_back(reply_header(radio_pkg::PKT_TYPE_RESP, hdr[59:48], hdr[31:0]));
      resp_data_q.push_back(model_readback());
      resp_sync_q.push_back(m_sync_cnt);
      send_word(hdr, 1'b0);
      send_word({pad, addr, data}, extra == 0);
      // Trailing words past the payload are ignored by the core
      if (extra != 0)
         send_word({$urandom, $urandom}, 1'b1);
   endtask

   task automatic send_tx(input int len);
      radio_pkg::word_t        hdr;
      radio_pkg::stream_word_t w;
      radio_pkg::stream_word_t pkt[$];
      hdr = random_header(radio_pkg::DEST_TX);
      for (int i = 0; i < len; i++) begin
         w.data = (i == 0) ? hdr : {$urandom, $urandom};
         w.last = (i == len - 1);
         pkt.push_back(w);
         tx_q.push_back(w);
      end
      m_tx_count++;
      if (m_ack_en) begin
         ack_hdr_q.push_back(reply_header(radio_pkg::PKT_TYPE_FC, hdr[59:48], hdr[31:0]));
         ack_data_q.push_back({32'd0, m_tx_count});
      end
      foreach (pkt[i])
         send_word(pkt[i].data, pkt[i].last);
   endtask

   task automatic send_drop(input int len);
      radio_pkg::word_t hdr;
      hdr = random_header(($urandom % 2) ? radio_pkg::DEST_RXCMD : radio_pkg::DEST_RXFC);
      for (int i = 0; i < len; i++)
         send_word((i == 0) ? hdr : {$urandom, $urandom}, i == len - 1);
   endtask

   // Returns 2 ns after an edge once every expected word has come out
   task automatic wait_idle();
      do
         @(negedge bus_clk);
      while (tx_q.size() != 0 || resp_data_q.size() != 0 || ack_data_q.size() != 0);
      @(posedge bus_clk);
      #2;
   endtask

   task automatic randomize_ready();
      forever begin
         @(posedge bus_clk);
         #2;
         i_out_tready = ($urandom % 4) != 0;
         i_tx_tready  = ($urandom % 4) != 0;
      end
   endtask

   //////////////////////////////
   // Output monitors
   task automatic take_tx_word(input radio_pkg::stream_word_t w);
      radio_pkg::stream_word_t exp;
      if (tx_q.size() == 0)
         fail_run($sformatf("transmit word %h came out with none expected", w.data));
      exp = tx_q.pop_front();
      check_word("tx data", exp.data, w.data);
      check_flag("tx last", exp.last, w.last);
   endtask

   task automatic take_out_word(input radio_pkg::stream_word_t w);
      if (out_state == 0) begin
         if (w.data[63:60] == radio_pkg::PKT_TYPE_RESP && resp_hdr_q.size() != 0) begin
            check_word("response header", resp_hdr_q.pop_front(), w.data);
            check_count("dac sync pulses", resp_sync_q.pop_front(), sync_seen);
            out_state = 1;
         end else if (w.data[63:60] == radio_pkg::PKT_TYPE_FC && ack_hdr_q.size() != 0) begin
            check_word("ack header", ack_hdr_q.pop_front(), w.data);
            out_state = 2;
         end else begin
            fail_run($sformatf("unexpected outbound packet with header %h", w.data));
         end
         check_flag("header last", 1'b0, w.last);
      end else if (out_state == 1) begin
         check_word("response payload", resp_data_q.pop_front(), w.data);
         check_flag("response last", 1'b1, w.last);
         out_state = 0;
      end else begin
         check_word("ack payload", ack_data_q.pop_front(), w.data);
         check_flag("ack last", 1'b1, w.last);
         out_state = 0;
      end
   endtask

   always @(posedge bus_clk) begin
      if (!bus_rst) begin
         if (o_sync_dacs)
            sync_seen++;
         if (o_tx_tvalid && i_tx_tready)
            take_tx_word(o_tx);
         if (o_out_tvalid && i_out_tready)
            take_out_word(o_out);
      end
   end

   always @(negedge bus_clk) begin
      if (uut.u_props.fail_cnt != 0)
         fail_run("a bound assertion on radio_core failed");
   end

   initial begin
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge bus_clk);
         cycle_cnt++;
      end
      $display("Run stopped because the DUT made no progress within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
   end

   //////////////////////////////
   // Test sequence
   initial begin
      int kind;
      void'($urandom(32'hc488_7928));
      i_in         = '0;
      i_in_tvalid  = 1'b0;
      i_out_tready = 1'b0;
      i_tx_tready  = 1'b0;
      i_misc_ins   = '0;
      fork
         randomize_ready();
      join_none
      wait (bus_rst == 1'b0);
      @(posedge bus_clk);
      #2;

      test_name = "test_word";
      send_cmd(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_TEST));
      repeat (N_TEST)
         send_cmd(radio_pkg::SR_TEST, $urandom);

      test_name = "misc_readback";
      repeat (N_MISC) begin
         send_cmd(radio_pkg::SR_MISC_OUTS, $urandom);
         wait_idle();
         check_data("o_misc_outs", m_misc_outs, o_misc_outs);
      end
      i_misc_ins = $urandom;
      m_misc_ins = i_misc_ins;
      send_cmd(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_MISC));
      send_cmd(radio_pkg::SR_MISC_OUTS, $urandom);
      send_cmd(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_RADIO_NUM));

      test_name = "dac_sync";
      repeat (N_SYNC)
         send_cmd(radio_pkg::SR_DACSYNC, $urandom);

      // Mixed traffic with acknowledges on
      test_name = "tx_ack";
      send_cmd(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_TEST));
      send_cmd(radio_pkg::SR_TX_ACK_EN, 32'd1);
      wait_idle();
      repeat (N_MIXED) begin
         kind = $urandom % 6;
         if (kind < 3)
            send_tx(1 + $urandom % 6);
         else if (kind == 3)
            send_cmd(radio_pkg::SR_TEST, $urandom);
         else
            send_drop(1 + $urandom % 4);
      end
      wait_idle();

      test_name = "tx_count";
      send_cmd(radio_pkg::SR_TX_ACK_EN, 32'd0);
      wait_idle();
      repeat (N_NOACK)
         send_tx(1 + $urandom % 6);
      wait_idle();
      send_cmd(radio_pkg::SR_READBACK, 32'(radio_pkg::RB_TX_COUNT));
      wait_idle();

      // Quiet period, stray output is caught by the monitors
      repeat (50) @(posedge bus_clk);
      check_count("total dac sync pulses", m_sync_cnt, sync_seen);
      check_data("o_misc_outs", m_misc_outs, o_misc_outs);
      @(negedge bus_clk);
      if (uut.u_props.fail_cnt == 0) begin
         $display("TESTS PASSED");
         $finish;
      end else begin
         $display("TESTS FAILED");
         $fatal(1, "assertion failures");
      end
   end

endmodule

/* sim/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clock_gen #(
   parameter int RST_CYCLES = 8
) (
   output logic o_bus_clk,
   output logic o_bus_rst
);

   // 20 ns period
   initial begin
      o_bus_clk = 1'b0;
      forever #10 o_bus_clk = ~o_bus_clk;
   end

   // Reset spans a fixed number of rising edges
   initial begin
      o_bus_rst = 1'b1;
      repeat (RST_CYCLES) @(posedge o_bus_clk);
      #2;
      o_bus_rst = 1'b0;
   end

endmodule

/* src.f */
common/radio_pkg.sv
logic/radio_demux.sv
logic/word_fifo.sv
ctrl/ctrl_proc.sv
ctrl/settings_regs.sv
logic/tx_ack_gen.sv
logic/radio_out_mux.sv
logic/radio_core.sv
sim/tb_clock_gen.sv
sim/radio_core_properties.sv
sim/radio_core_tb.sv
